// File: Makefile
# Verilator build and run of the CLIC testbench
# Run from the project root, the trace path is relative to it

VERILATOR ?= verilator
TB_TOP    ?= tb_clic_top
RTL_TOP   ?= clic_top
FILELIST  ?= clic_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= PASS: all tests

BIN := $(OBJ_DIR)/V$(TB_TOP)
SRCS := $(wildcard src/*.sv verification/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: clic_subsys.f
src/clic_pkg.sv
src/clic_sel_if.sv
src/clic_apb_regs.sv
src/clic_arbiter.sv
src/clic_irq_accept.sv
src/clic_top.sv
verification/clic_top_assert.sv
verification/tb_clic_top.sv

// File: src/clic_apb_regs.sv
// APB register block and pending capture of the CLIC
// Zero wait states; unmapped accesses read 0 and raise PSLVERR
// Writes to the pending register are refused with PSLVERR
// Sources are rising-edge triggered; a new edge beats a clear in the same cycle
module clic_apb_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // APB slave
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic [clic_pkg::ApbAddrWidth-1:0]      paddr_i,
  input  logic [clic_pkg::ApbDataWidth-1:0]      pwdata_i,
  output logic [clic_pkg::ApbDataWidth-1:0]      prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o,
  // Sources and clear from arbiter
  input  logic [clic_pkg::NumSrc-1:0]            irq_src_i,
  input  logic                                   clr_valid_i,
  input  logic [clic_pkg::IdWidth-1:0]           clr_id_i,
  // Per-source state
  output logic [clic_pkg::NumSrc-1:0]            pending_o,
  output logic [clic_pkg::NumSrc-1:0]            enable_o,
  output logic [clic_pkg::LevelWidth-1:0]        src_level_o [clic_pkg::NumSrc],
  output clic_pkg::priv_lvl_t                    src_priv_o [clic_pkg::NumSrc],
  // Hart-level state
  output logic [clic_pkg::LevelWidth-1:0]        mintthresh_o,
  output logic [clic_pkg::LevelWidth-1:0]        sintthresh_o,
  output clic_pkg::mintstatus_t                  mintstatus_o,
  output logic                                   sie_o
);

  logic                                 access;    // APB access phase
  logic                                 reg_hit;   // Address is mapped
  logic                                 wr_en;
  logic                                 src_hit;
  logic [clic_pkg::ApbAddrWidth-1:0]    src_off;
  logic [clic_pkg::IdWidth-1:0]         src_idx;

  logic [clic_pkg::LevelWidth-1:0]      mintthresh_q;
  logic [clic_pkg::LevelWidth-1:0]      sintthresh_q;
  clic_pkg::mintstatus_t                mintstatus_q;
  logic                                 sie_q;
  logic [clic_pkg::NumSrc-1:0]          enable_q;
  logic [clic_pkg::LevelWidth-1:0]      level_q [clic_pkg::NumSrc];
  clic_pkg::priv_lvl_t                  priv_q [clic_pkg::NumSrc];

  logic [clic_pkg::NumSrc-1:0]          src_q;     // Sources one cycle ago
  logic [clic_pkg::NumSrc-1:0]          src_rise;
  logic [clic_pkg::NumSrc-1:0]          pending_d;
  logic [clic_pkg::NumSrc-1:0]          pending_q;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign access  = psel_i & penable_i;
  assign src_off = paddr_i - clic_pkg::RegSrcBase;
  assign src_idx = src_off[clic_pkg::IdWidth+1:2];  // Word index in source window
  assign src_hit = (paddr_i >= clic_pkg::RegSrcBase)
                 && (src_off < clic_pkg::ApbAddrWidth'(4 * clic_pkg::NumSrc))
                 && (src_off[1:0] == 2'b00);

  // Read mux, also yields the mapped flag
  always_comb begin
    reg_hit  = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      clic_pkg::RegMintthresh: prdata_o[clic_pkg::LevelWidth-1:0] = mintthresh_q;
      clic_pkg::RegSintthresh: prdata_o[clic_pkg::LevelWidth-1:0] = sintthresh_q;
      clic_pkg::RegMintstatus: prdata_o[15:0] = mintstatus_q;
      clic_pkg::RegCtrl:       prdata_o[0] = sie_q;
      clic_pkg::RegPending:    prdata_o[clic_pkg::NumSrc-1:0] = pending_q;
      default: begin
        if (src_hit) begin
          prdata_o[0]    = enable_q[src_idx];
          prdata_o[2:1]  = priv_q[src_idx];
          prdata_o[15:8] = level_q[src_idx];
        end else begin
          reg_hit = 1'b0;  // Hole in the map
        end
      end
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~reg_hit | (pwrite_i & (paddr_i == clic_pkg::RegPending)));
  assign wr_en     = access & pwrite_i & ~pslverr_o;

  // ------------------------------
  // Configuration registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mintthresh_q <= '0;
      sintthresh_q <= '0;
      mintstatus_q <= '0;
      sie_q        <= 1'b0;
      enable_q     <= '0;
      for (int i = 0; i < clic_pkg::NumSrc; i++) begin
        level_q[i] <= '0;
        priv_q[i]  <= clic_pkg::PrivU;
      end
    end else if (wr_en) begin
      case (paddr_i)
        clic_pkg::RegMintthresh: mintthresh_q <= pwdata_i[clic_pkg::LevelWidth-1:0];
        clic_pkg::RegSintthresh: sintthresh_q <= pwdata_i[clic_pkg::LevelWidth-1:0];
        clic_pkg::RegMintstatus: mintstatus_q <= pwdata_i[15:0];
        clic_pkg::RegCtrl:       sie_q        <= pwdata_i[0];
        default: begin  // Only source slots get here
          enable_q[src_idx] <= pwdata_i[0];
          priv_q[src_idx]   <= clic_pkg::priv_lvl_t'(pwdata_i[2:1]);
          level_q[src_idx]  <= pwdata_i[15:8];
        end
      endcase
    end
  end

  // ------------------------------
  // Pending capture
  // ------------------------------
  assign src_rise = irq_src_i & ~src_q;  // Sampled low, then high

  always_comb begin
    pending_d = pending_q;
    if (clr_valid_i) begin
      pending_d[clr_id_i] = 1'b0;
    end
    pending_d = pending_d | src_rise;  // Fresh edge has priority
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q     <= '0;
      pending_q <= '0;
    end else begin
      src_q     <= irq_src_i;
      pending_q <= pending_d;
    end
  end

  assign pending_o    = pending_q;
  assign enable_o     = enable_q;
  assign src_level_o  = level_q;
  assign src_priv_o   = priv_q;
  assign mintthresh_o = mintthresh_q;
  assign sintthresh_o = sintthresh_q;
  assign mintstatus_o = mintstatus_q;
  assign sie_o        = sie_q;

endmodule

// File: src/clic_arbiter.sv
// Picks the highest-level pending and enabled source
// Equal levels resolve to the lowest id; level 0 still counts as valid
// The clear reaches the pending bit at the edge after sel.ready
module clic_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]     pending_i,
  input  logic [clic_pkg::NumSrc-1:0]     enable_i,
  input  logic [clic_pkg::LevelWidth-1:0] src_level_i [clic_pkg::NumSrc],
  input  clic_pkg::priv_lvl_t             src_priv_i [clic_pkg::NumSrc],
  // Pending clear toward the registers
  output logic                            clr_valid_o,
  output logic [clic_pkg::IdWidth-1:0]    clr_id_o,
  clic_sel_if.arb                         sel
);

  logic [clic_pkg::NumSrc-1:0]     cand;       // Pending and enabled
  logic                            found;
  logic [clic_pkg::IdWidth-1:0]    best_id;
  logic [clic_pkg::LevelWidth-1:0] best_level;
  logic                            clr_go;
  logic                            clr_block_q;  // Clear issued last cycle
  logic [clic_pkg::IdWidth-1:0]    clr_id_q;     // ... for this id

  assign cand = pending_i & enable_i;

  // ------------------------------
  // Max-level scan
  // ------------------------------
  always_comb begin
    found      = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int i = 0; i < clic_pkg::NumSrc; i++) begin
      // Strictly greater keeps the lower id on a tie
      if (cand[i] && (!found || (src_level_i[i] > best_level))) begin
        found      = 1'b1;
        best_id    = clic_pkg::IdWidth'(i);
        best_level = src_level_i[i];
      end
    end
  end

  assign sel.valid = found;
  assign sel.id    = best_id;
  assign sel.level = best_level;
  assign sel.priv  = src_priv_i[best_id];

  // ------------------------------
  // Pending clear
  // ------------------------------
  // Ack held over two cycles must not eat a re-raised edge of the same id
  assign clr_go      = sel.ready & found & ~(clr_block_q & (clr_id_q == best_id));
  assign clr_valid_o = clr_go;
  assign clr_id_o    = best_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_block_q <= 1'b0;
    end else begin
      clr_block_q <= clr_go;  // Lasts one cycle
    end
  end

  always_ff @(posedge clk_i) begin
    clr_id_q <= best_id;
  end

endmodule

// File: src/clic_irq_accept.sv
// Acceptance stage between arbiter and core
// Effective threshold is the max of the threshold register and mintstatus
// S interrupts need sie; U mode takes everything that is valid
// Kill is acked only with no interrupt in flight and none raised this cycle
module clic_irq_accept (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  clic_sel_if.acc                         sel,
  // Hart state
  input  clic_pkg::priv_lvl_t             priv_lvl_i,
  input  logic [clic_pkg::LevelWidth-1:0] mintthresh_i,
  input  logic [clic_pkg::LevelWidth-1:0] sintthresh_i,
  input  clic_pkg::mintstatus_t           mintstatus_i,
  input  logic                            sie_i,
  // Core side
  input  logic                            irq_ack_i,
  input  logic                            kill_req_i,
  output logic                            irq_req_o,
  output clic_pkg::priv_lvl_t             irq_priv_o,
  output logic [clic_pkg::Xlen-1:0]       irq_cause_o,
  output logic                            kill_ack_o
);

  logic [clic_pkg::LevelWidth-1:0] eff_mthresh;
  logic [clic_pkg::LevelWidth-1:0] eff_sthresh;
  logic                            inflight_d;
  logic                            inflight_q;

  // ------------------------------
  // Thresholds
  // ------------------------------
  assign eff_mthresh = (mintthresh_i > mintstatus_i.mil) ? mintthresh_i : mintstatus_i.mil;
  assign eff_sthresh = (sintthresh_i > mintstatus_i.sil) ? sintthresh_i : mintstatus_i.sil;

  // Request decision per hart mode
  always_comb begin
    irq_req_o = 1'b0;
    unique case (priv_lvl_i)
      clic_pkg::PrivM: begin
        // Only higher M levels preempt M mode
        if (sel.priv == clic_pkg::PrivM) begin
          irq_req_o = sel.valid && (sel.level > eff_mthresh);
        end
      end
      clic_pkg::PrivS: begin
        if (sel.priv == clic_pkg::PrivM) begin
          irq_req_o = sel.valid;  // M always beats S
        end else if (sel.priv == clic_pkg::PrivS) begin
          irq_req_o = sel.valid && sie_i && (sel.level > eff_sthresh);
        end
      end
      clic_pkg::PrivU: irq_req_o = sel.valid;
      default:         irq_req_o = 1'b0;  // Reserved mode
    endcase
  end

  assign irq_priv_o = sel.priv;

  // ------------------------------
  // Cause word
  // ------------------------------
  always_comb begin
    irq_cause_o                                                 = '0;
    irq_cause_o[clic_pkg::CauseIrqBit]                          = 1'b1;
    irq_cause_o[clic_pkg::CauseLevelLsb +: clic_pkg::LevelWidth] = sel.level;
    irq_cause_o[clic_pkg::IdWidth-1:0]                          = sel.id;  // Exception code
  end

  // ------------------------------
  // In-flight and kill
  // ------------------------------
  assign sel.ready  = irq_ack_i & (irq_req_o | inflight_q);
  assign kill_ack_o = kill_req_i & ~inflight_q & ~irq_req_o;

  // Set on request and dropped by the ack, even in the cycle the request rises
  assign inflight_d = (inflight_q | irq_req_o) & ~sel.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// File: src/clic_pkg.sv
// Shared constants and types of the CLIC
// Eight sources, 8-bit levels and a 32-bit hart; no virtualization, no SHV
// Register offsets are byte addresses on a 12-bit APB window
package clic_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned NumSrc       = 8;
  localparam int unsigned IdWidth      = 3;   // clog2(NumSrc)
  localparam int unsigned LevelWidth   = 8;
  localparam int unsigned Xlen         = 32;  // mcause width
  localparam int unsigned ApbAddrWidth = 12;
  localparam int unsigned ApbDataWidth = 32;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [ApbAddrWidth-1:0] RegMintthresh = 12'h000;
  localparam logic [ApbAddrWidth-1:0] RegSintthresh = 12'h004;
  localparam logic [ApbAddrWidth-1:0] RegMintstatus = 12'h008;  // mil 15:8, sil 7:0
  localparam logic [ApbAddrWidth-1:0] RegCtrl       = 12'h00C;  // Bit 0 sie
  localparam logic [ApbAddrWidth-1:0] RegPending    = 12'h010;  // Read only
  localparam logic [ApbAddrWidth-1:0] RegSrcBase    = 12'h100;  // One word per source

  // Cause word layout
  localparam int unsigned CauseIrqBit   = 31;
  localparam int unsigned CauseLevelLsb = 16;

  // ------------------------------
  // Types
  // ------------------------------
  // RISC-V privilege encoding, 2 is reserved
  typedef enum logic [1:0] {
    PrivU = 2'd0,
    PrivS = 2'd1,
    PrivM = 2'd3
  } priv_lvl_t;

  // Active interrupt levels of M and S mode
  typedef struct packed {
    logic [LevelWidth-1:0] mil;
    logic [LevelWidth-1:0] sil;
  } mintstatus_t;

endpackage

// File: src/clic_sel_if.sv
// Winner of the arbitration, handed to the acceptance stage
// Payload is combinational and only meaningful while valid is high
// ready is a single-cycle pulse that consumes the presented id
interface clic_sel_if;

  logic                            valid;  // Some enabled source pending
  logic [clic_pkg::IdWidth-1:0]    id;
  logic [clic_pkg::LevelWidth-1:0] level;
  clic_pkg::priv_lvl_t             priv;   // Target mode of the source
  logic                            ready;  // Core took it

  // Arbiter side
  modport arb (
    output valid, id, level, priv,
    input  ready
  );

  // Acceptance side
  modport acc (
    input  valid, id, level, priv,
    output ready
  );

endinterface

// File: src/clic_top.sv
// CLIC top: APB registers, arbiter and acceptance stage
// APB has no wait states; pready_o is constant high
// Source inputs are sampled on clk_i and must be synchronous to it
module clic_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // APB slave
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [clic_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [clic_pkg::ApbDataWidth-1:0] pwdata_i,
  output logic [clic_pkg::ApbDataWidth-1:0] prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  // Interrupt sources
  input  logic [clic_pkg::NumSrc-1:0]       irq_src_i,
  // Hart and core side
  input  clic_pkg::priv_lvl_t               priv_lvl_i,
  output logic                              irq_req_o,
  output clic_pkg::priv_lvl_t               irq_priv_o,
  output logic [clic_pkg::Xlen-1:0]         irq_cause_o,
  input  logic                              irq_ack_i,
  input  logic                              kill_req_i,
  output logic                              kill_ack_o
);

  logic [clic_pkg::NumSrc-1:0]     pending;
  logic [clic_pkg::NumSrc-1:0]     enable;
  logic [clic_pkg::LevelWidth-1:0] src_level [clic_pkg::NumSrc];
  clic_pkg::priv_lvl_t             src_priv [clic_pkg::NumSrc];
  logic [clic_pkg::LevelWidth-1:0] mintthresh;
  logic [clic_pkg::LevelWidth-1:0] sintthresh;
  clic_pkg::mintstatus_t           mintstatus;
  logic                            sie;
  logic                            clr_valid;  // Arbiter clears a pending bit
  logic [clic_pkg::IdWidth-1:0]    clr_id;

  clic_sel_if sel_if ();  // Arbiter to acceptance

  clic_apb_regs i_regs (
    .clk_i, .rst_ni,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .irq_src_i,
    .clr_valid_i  (clr_valid),
    .clr_id_i     (clr_id),
    .pending_o    (pending),
    .enable_o     (enable),
    .src_level_o  (src_level),
    .src_priv_o   (src_priv),
    .mintthresh_o (mintthresh),
    .sintthresh_o (sintthresh),
    .mintstatus_o (mintstatus),
    .sie_o        (sie)
  );

  clic_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .pending_i   (pending),
    .enable_i    (enable),
    .src_level_i (src_level),
    .src_priv_i  (src_priv),
    .clr_valid_o (clr_valid),
    .clr_id_o    (clr_id),
    .sel         (sel_if)
  );

  clic_irq_accept i_accept (
    .clk_i, .rst_ni,
    .sel          (sel_if),
    .priv_lvl_i,
    .mintthresh_i (mintthresh),
    .sintthresh_i (sintthresh),
    .mintstatus_i (mintstatus),
    .sie_i        (sie),
    .irq_ack_i, .kill_req_i,
    .irq_req_o, .irq_priv_o, .irq_cause_o, .kill_ack_o
  );

endmodule

// File: verification/clic_top_assert.sv
// Core-side protocol checks on the CLIC top
// Sampled on the rising clock edge, off while rst_ni is low
// Also watches the top's internal pending and enable vectors
module clic_top_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        irq_req_i,
  input logic [clic_pkg::Xlen-1:0]   irq_cause_i,
  input logic                        irq_ack_i,
  input logic                        kill_req_i,
  input logic                        kill_ack_i,
  input logic [clic_pkg::NumSrc-1:0] pending_i,
  input logic [clic_pkg::NumSrc-1:0] enable_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Core handshake
  // ------------------------------
  // Cause names a source that is really pending and enabled
  cause_irq_bit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_i |-> irq_cause_i[clic_pkg::CauseIrqBit]
                  && pending_i[irq_cause_i[clic_pkg::IdWidth-1:0]]
                  && enable_i[irq_cause_i[clic_pkg::IdWidth-1:0]])
    else $error("irq_cause_o lacks the interrupt bit or names no pending enabled source");

  kill_vs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_req_i && !irq_ack_i |=> !kill_ack_i)  // Unacked request stays in flight
    else $error("kill_ack_o high while a request was outstanding and not acknowledged");

  kill_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kill_ack_i |-> kill_req_i)
    else $error("kill_ack_o high without kill_req_i");

  // Back-pressure keeps pending bits until the core acks
  pend_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !irq_ack_i |=> (($past(pending_i) & ~pending_i) == '0))
    else $error("A pending bit cleared without irq_ack_i");

endmodule

// File: verification/clic_trace.txt
# One operation per line, all numbers hex, T starts a named test
# T name | W addr data | R addr data err | P priv | S mask | E req cause priv | A | K kill_ack
T regs
W 000 000000AB
R 000 000000AB 0
W 008 0000A5C3
R 008 0000A5C3 0
W 00C FFFFFFFF
R 00C 00000001 0
W 104 FFFFFFFF
R 104 0000FF07 0
R 120 00000000 1
W 010 000000FF
R 010 00000000 0
T arbitration
P 0
W 100 00001001
W 108 00004001
W 10C 0000FF00
W 114 00004001
W 11C 00002001
S AD
E 1 80400002 0
A
E 1 80400005 0
A
E 1 80200007 0
A
E 1 80100000 0
A
E 0 00000000 0
R 010 00000008 0
T m_threshold
P 3
W 000 00000040
W 008 00000000
W 104 00004007
S 02
E 0 00000000 0
W 000 00000010
W 008 00004000
E 0 00000000 0
W 008 00003F00
E 1 80400001 3
A
E 0 00000000 0
W 110 0000F003
S 10
E 0 00000000 0
T s_rules
P 1
E 1 80F00004 1
W 00C 00000000
E 0 00000000 0
W 00C 00000001
W 004 000000F0
E 0 00000000 0
W 004 000000EF
E 1 80F00004 1
W 008 000000F0
E 0 00000000 0
W 008 00000000
A
E 0 00000000 0
W 000 000000FF
W 118 00000107
S 40
E 1 80010006 3
A
E 0 00000000 0
W 11C 0000FF06
S 80
E 0 00000000 0
T kill
K 1
S 40
E 1 80010006 3
K 0
A
K 1

// File: verification/tb_clic_top.sv
// Trace-driven testbench of the CLIC top
// Reads verification/clic_trace.txt, so it must run from the project root
// Inputs change on the rising edge, outputs are sampled on the falling edge
module tb_clic_top;
  timeunit 1ns;
  timeprecision 100ps;

  logic                              clk_i;
  logic                              rst_ni;
  logic                              psel_i;
  logic                              penable_i;
  logic                              pwrite_i;
  logic [clic_pkg::ApbAddrWidth-1:0] paddr_i;
  logic [clic_pkg::ApbDataWidth-1:0] pwdata_i;
  logic [clic_pkg::ApbDataWidth-1:0] prdata_o;
  logic                              pready_o;
  logic                              pslverr_o;
  logic [clic_pkg::NumSrc-1:0]       irq_src_i;
  clic_pkg::priv_lvl_t               priv_lvl_i;
  logic                              irq_req_o;
  clic_pkg::priv_lvl_t               irq_priv_o;
  logic [clic_pkg::Xlen-1:0]         irq_cause_o;
  logic                              irq_ack_i;
  logic                              kill_req_i;
  logic                              kill_ack_o;

  int    errors;
  int    checks;
  int    tests_run;
  int    tests_failed;
  int    test_err_start;  // Error count when the test began
  string cur_test;
  int    cycles;
  int    limit_cycles;    // 0 until the trace length is known

  clic_top uut (.*);

  bind clic_top clic_top_assert i_assert (
    .clk_i, .rst_ni, .kill_req_i, .irq_ack_i,
    .irq_req_i   (irq_req_o),
    .irq_cause_i (irq_cause_o),
    .kill_ack_i  (kill_ack_o),
    .pending_i   (pending),
    .enable_i    (enable)
  );

  always #50 clk_i = ~clk_i;  // 100 ns period

  // Watchdog
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit_cycles > 0 && cycles >= limit_cycles) begin
      $display("Timeout: trace still running after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ------------------------------
  // Checks and test bookkeeping
  // ------------------------------
  task automatic check_value(input string sig, input logic [31:0] expv, input logic [31:0] got);
    checks++;
    assert (got === expv)
      else begin
        $display("Mismatch at %0d ns: %s expected %h, got %h", $time, sig, expv, got);
        errors++;
      end
  endtask

  task automatic end_test();
    if (cur_test.len() > 0) begin
      if (errors == test_err_start) begin
        $display("Test %s: ok", cur_test);
      end else begin
        $display("Test %s: FAILED with %0d errors", cur_test, errors - test_err_start);
        tests_failed++;
      end
    end
    cur_test = "";
  endtask

  task automatic start_test(input string name);
    end_test();
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  // Error response of a write, from the register map
  function automatic logic write_err(input logic [11:0] addr);
    logic mapped;
    mapped = (addr == clic_pkg::RegMintthresh) || (addr == clic_pkg::RegSintthresh)
          || (addr == clic_pkg::RegMintstatus) || (addr == clic_pkg::RegCtrl)
          || (addr == clic_pkg::RegPending)
          || ((addr >= clic_pkg::RegSrcBase) && (addr < clic_pkg::RegSrcBase + 12'h020)
              && (addr[1:0] == 2'b00));
    return !mapped || (addr == clic_pkg::RegPending);  // Pending is read only
  endfunction

  // ------------------------------
  // Bus and core drivers
  // ------------------------------
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_i);  // Setup phase
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);  // Access phase, no wait states
    rdata = prdata_o;
    err   = pslverr_o;
    check_value("pready_o", 32'(1'b1), 32'(pready_o));
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic pulse_sources(input logic [7:0] mask);
    @(posedge clk_i);
    irq_src_i <= mask;
    @(posedge clk_i);  // Edge captured here
    irq_src_i <= '0;
  endtask

  task automatic ack_irq();
    @(posedge clk_i);
    irq_ack_i <= 1'b1;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
  endtask

  task automatic check_kill(input logic exp);
    @(posedge clk_i);
    kill_req_i <= 1'b1;
    @(negedge clk_i);
    check_value("kill_ack_o", 32'(exp), 32'(kill_ack_o));
    @(posedge clk_i);
    kill_req_i <= 1'b0;
  endtask

  task automatic check_irq(input logic exp_req, input logic [31:0] cause, input logic [31:0] priv);
    @(negedge clk_i);
    check_value("irq_req_o", 32'(exp_req), 32'(irq_req_o));
    if (exp_req) begin  // Payload only valid with a request
      check_value("irq_cause_o", cause, irq_cause_o);
      check_value("irq_priv_o", priv, 32'(irq_priv_o));
    end
  endtask

  // ------------------------------
  // Trace reader
  // ------------------------------
  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != -1 && c != 10) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic run_trace(input int fd);
    string       op;
    string       name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] rd;
    logic        err;
    int          rc;
    rc = $fscanf(fd, "%s", op);
    while (rc == 1) begin
      case (op)
        "#": skip_line(fd);
        "T": begin
          rc = $fscanf(fd, "%s", name);
          start_test(name);
        end
        "W": begin
          rc = $fscanf(fd, "%h %h", a, b);
          apb_access(1'b1, a[11:0], b, rd, err);
          check_value("pslverr_o", 32'(write_err(a[11:0])), 32'(err));
        end
        "R": begin
          rc = $fscanf(fd, "%h %h %h", a, b, c);
          apb_access(1'b0, a[11:0], '0, rd, err);
          check_value("prdata_o", b, rd);
          check_value("pslverr_o", c, 32'(err));
        end
        "P": begin
          rc = $fscanf(fd, "%h", a);
          @(posedge clk_i);
          priv_lvl_i <= clic_pkg::priv_lvl_t'(a[1:0]);
        end
        "S": begin
          rc = $fscanf(fd, "%h", a);
          pulse_sources(a[7:0]);
        end
        "E": begin
          rc = $fscanf(fd, "%h %h %h", a, b, c);
          check_irq(a[0], b, c);
        end
        "A": ack_irq();
        "K": begin
          rc = $fscanf(fd, "%h", a);
          check_kill(a[0]);
        end
        default: begin
          $display("Unknown trace operation %s, rest of the line ignored", op);
          errors++;
          skip_line(fd);
        end
      endcase
      rc = $fscanf(fd, "%s", op);
    end
  endtask

  initial begin : main
    int fd;
    int nlines;
    int c;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    irq_src_i    = '0;
    priv_lvl_i   = clic_pkg::PrivM;
    irq_ack_i    = 1'b0;
    kill_req_i   = 1'b0;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycles       = 0;
    limit_cycles = 0;
    cur_test     = "";
    nlines       = 0;
    fd = $fopen("verification/clic_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file verification/clic_trace.txt");
      errors++;
    end else begin
      c = $fgetc(fd);  // Count lines for the watchdog
      while (c != -1) begin
        if (c == 10) nlines++;
        c = $fgetc(fd);
      end
      $fclose(fd);
      limit_cycles = nlines * 10 + 8;
      fd = $fopen("verification/clic_trace.txt", "r");
      repeat (8) @(posedge clk_i);
      rst_ni <= 1'b1;
      start_test("reset");
      @(negedge clk_i);
      check_value("irq_req_o", 32'(1'b0), 32'(irq_req_o));
      check_value("kill_ack_o", 32'(1'b0), 32'(kill_ack_o));
      check_value("pslverr_o", 32'(1'b0), 32'(pslverr_o));
      run_trace(fd);
      end_test();
      $fclose(fd);
    end
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
